//--- switch_pkg.sv
package switch_pkg;

    localparam int num_ports  = 4;
    localparam int num_prios  = 2;
    localparam int num_queues = num_ports * num_prios;  // one per dest and priority
    localparam int port_w     = $clog2(num_ports);
    localparam int qid_w      = $clog2(num_queues);
    localparam int word_w     = 16;
    localparam int max_len    = 31;                     // data words after the header

    typedef struct packed {
        logic [1:0] dest;
        logic       prior;
        logic [7:0] spare;
        logic [4:0] length;
    } pkt_hdr_t;

    // first word of a packet is read as a header, the rest as plain data
    typedef union packed {
        pkt_hdr_t          hdr;
        logic [word_w-1:0] data;
    } pkt_word_u;

endpackage

//--- buffer_pkg.sv
package buffer_pkg;

    localparam int page_words = 8;
    localparam int num_pages  = 64;
    localparam int ofs_w      = $clog2(page_words);
    localparam int ptr_w      = $clog2(num_pages);
    localparam int addr_w     = ptr_w + ofs_w;        // {page, offset}

    typedef logic [ptr_w-1:0] page_ptr_t;
    typedef logic [ofs_w-1:0] word_ofs_t;

    typedef struct packed {
        logic [2:0] qid;      // {dest, prior}
        page_ptr_t  first;    // first page, also the packet key
    } pkt_desc_t;

endpackage

//--- page_if.sv
`timescale 1ns/1ps

interface page_if;
    import switch_pkg::*;
    import buffer_pkg::*;

    logic              req;      // page staged, held until done
    logic [ofs_w:0]    words;    // 1 to 8
    logic              last;
    logic              first;
    logic [qid_w-1:0]  qid;
    logic [word_w-1:0] rd_word;
    logic              grant;
    word_ofs_t         rd_ofs;
    logic              done;

    modport ingress (output req, words, last, first, qid, rd_word, input grant, rd_ofs, done);
    modport writer  (input req, words, last, first, qid, rd_word, output grant, rd_ofs, done);
endinterface

//--- desc_if.sv
`timescale 1ns/1ps

interface desc_if;
    import buffer_pkg::*;

    logic      valid;    // single cycle, never stalled
    pkt_desc_t desc;

    modport writer (output valid, desc);
    modport reader (input valid, desc);
endinterface

//--- ingress_port.sv
`timescale 1ns/1ps

module ingress_port (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          sop,
    input  logic                          eop,
    input  logic                          vld,
    input  logic [switch_pkg::word_w-1:0] data,
    output logic                          full,
    output logic                          almost_full,
    page_if.ingress                       pg
);
    import switch_pkg::*;
    import buffer_pkg::*;

    logic [word_w-1:0] stage [page_words];
    logic [ofs_w:0]    cnt;       // words held in the staging page
    logic              staged;
    logic              take;
    pkt_word_u         w;

    assign w.data = data;
    assign take   = vld && !staged;  // words are ignored while a page waits

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt    <= '0;
            staged <= 1'b0;
        end else if (pg.done) begin
            cnt    <= '0;
            staged <= 1'b0;
        end else if (take) begin
            cnt <= cnt + 1'b1;
            if (eop || cnt == page_words - 1) begin
                staged <= 1'b1;    // page full or packet ended
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            stage[cnt[ofs_w-1:0]] <= data;
            pg.last               <= eop;
            if (cnt == 0) begin
                pg.first <= sop;
            end
            if (sop) begin
                pg.qid <= {w.hdr.dest, w.hdr.prior};
            end
        end
    end

    assign pg.req      = staged;
    assign pg.words    = cnt;
    assign pg.rd_word  = stage[pg.rd_ofs];
    assign full        = staged;
    assign almost_full = (cnt == page_words - 1);
endmodule

//--- page_writer.sv
`timescale 1ns/1ps

module page_writer (
    input  logic                          clk,
    input  logic                          arst_n,
    page_if.writer                        pg [switch_pkg::num_ports],
    desc_if.writer                        dq,
    output logic                          we,
    output logic [buffer_pkg::addr_w-1:0] waddr,
    output logic [switch_pkg::word_w-1:0] wdata,
    output logic                          link_we,
    output buffer_pkg::page_ptr_t         link_from,
    output buffer_pkg::page_ptr_t         link_to,
    output logic                          free_pop,
    input  buffer_pkg::page_ptr_t         free_ptr,
    input  logic                          free_empty
);
    import switch_pkg::*;
    import buffer_pkg::*;

    logic [num_ports-1:0] req_v;
    logic [num_ports-1:0] first_v;
    logic [num_ports-1:0] last_v;
    logic [ofs_w:0]       words_v [num_ports];
    logic [qid_w-1:0]     qid_v [num_ports];
    logic [word_w-1:0]    word_v [num_ports];
    page_ptr_t            first_pg [num_ports];   // head page of the open packet
    page_ptr_t            prev_pg [num_ports];    // last page written per port
    logic [port_w-1:0]    cur;
    logic [port_w-1:0]    pick;
    logic                 found, start, busy, grant_q, done_q, copy_end;
    word_ofs_t            ofs;
    page_ptr_t            page;

    for (genvar i = 0; i < num_ports; i++) begin : g_port
        assign req_v[i]     = pg[i].req;
        assign first_v[i]   = pg[i].first;
        assign last_v[i]    = pg[i].last;
        assign words_v[i]   = pg[i].words;
        assign qid_v[i]     = pg[i].qid;
        assign word_v[i]    = pg[i].rd_word;
        assign pg[i].grant  = grant_q && cur == port_w'(i);
        assign pg[i].done   = done_q && cur == port_w'(i);
        assign pg[i].rd_ofs = ofs;
    end

    // round robin, nearest requester after cur wins
    always_comb begin
        found = 1'b0;
        pick  = cur;
        for (int k = num_ports; k >= 1; k--) begin
            if (req_v[port_w'(cur + k)]) begin
                found = 1'b1;
                pick  = port_w'(cur + k);
            end
        end
    end

    assign start     = found && !busy && !done_q && !free_empty;  // done cycle still sees req
    assign copy_end  = busy && ({1'b0, ofs} + 1'b1 == words_v[cur]);
    assign free_pop  = start;
    assign we        = busy;
    assign waddr     = {page, ofs};
    assign wdata     = word_v[cur];
    assign link_we   = start && !first_v[pick];   // chain from previous page
    assign link_from = prev_pg[pick];
    assign link_to   = free_ptr;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy     <= 1'b0;
            grant_q  <= 1'b0;
            done_q   <= 1'b0;
            dq.valid <= 1'b0;
            cur      <= port_w'(num_ports - 1);
        end else begin
            grant_q  <= start;
            done_q   <= copy_end;
            dq.valid <= done_q && last_v[cur];
            if (start) begin
                busy <= 1'b1;
                cur  <= pick;
            end else if (copy_end) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            page          <= free_ptr;
            ofs           <= '0;
            prev_pg[pick] <= free_ptr;
            if (first_v[pick]) begin
                first_pg[pick] <= free_ptr;
            end
        end else if (busy) begin
            ofs <= ofs + 1'b1;
        end
        if (done_q) begin
            dq.desc.qid   <= qid_v[cur];
            dq.desc.first <= first_pg[cur];
        end
    end
endmodule

//--- buffer_memory.sv
`timescale 1ns/1ps

module buffer_memory (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          we,
    input  logic [buffer_pkg::addr_w-1:0] waddr,
    input  logic [switch_pkg::word_w-1:0] wdata,
    input  logic [buffer_pkg::addr_w-1:0] raddr,
    output logic [switch_pkg::word_w-1:0] rdata,
    input  logic                          link_we,
    input  buffer_pkg::page_ptr_t         link_from,
    input  buffer_pkg::page_ptr_t         link_to,
    input  buffer_pkg::page_ptr_t         link_addr,
    output buffer_pkg::page_ptr_t         link_data,
    input  logic                          free_pop,
    output buffer_pkg::page_ptr_t         free_ptr,
    output logic                          free_empty,
    input  logic                          free_push,
    input  buffer_pkg::page_ptr_t         free_in
);
    import switch_pkg::*;
    import buffer_pkg::*;

    logic [word_w-1:0] mem [num_pages * page_words];
    page_ptr_t         link [num_pages];       // next page of the same packet
    page_ptr_t         fl [num_pages];         // free page ring
    page_ptr_t         fl_head;
    page_ptr_t         fl_tail;
    logic [ptr_w:0]    fl_cnt;

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];     // one cycle read
        if (link_we) begin
            link[link_from] <= link_to;
        end
    end

    assign link_data = link[link_addr];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < num_pages; i++) begin
                fl[i] <= page_ptr_t'(i);   // every page free
            end
            fl_head <= '0;
            fl_tail <= '0;
            fl_cnt  <= (ptr_w + 1)'(num_pages);
        end else begin
            if (free_push) begin
                fl[fl_tail] <= free_in;
                fl_tail     <= fl_tail + 1'b1;
            end
            if (free_pop) begin
                fl_head <= fl_head + 1'b1;
            end
            fl_cnt <= fl_cnt + (ptr_w + 1)'(free_push) - (ptr_w + 1)'(free_pop);
        end
    end

    assign free_ptr   = fl[fl_head];
    assign free_empty = (fl_cnt == 0);
endmodule

//--- egress_reader.sv
`timescale 1ns/1ps

module egress_reader (
    input  logic                          clk,
    input  logic                          arst_n,
    desc_if.reader                        dq,
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  logic [2:0]                    wb_adr,
    output logic [switch_pkg::word_w-1:0] wb_dat_o,
    output logic                          wb_ack,
    output logic [buffer_pkg::addr_w-1:0] raddr,
    input  logic [switch_pkg::word_w-1:0] rdata,
    output buffer_pkg::page_ptr_t         link_addr,
    input  buffer_pkg::page_ptr_t         link_data,
    output logic                          free_push,
    output buffer_pkg::page_ptr_t         free_in
);
    import switch_pkg::*;
    import buffer_pkg::*;

    page_ptr_t             head [num_queues];
    page_ptr_t             tail [num_queues];
    page_ptr_t             pnext [num_pages];   // next packet, keyed by first page
    logic [num_queues-1:0] q_ne;
    logic [num_ports-1:0]  active;              // destination is mid-packet
    page_ptr_t             cur_pg [num_ports];
    word_ofs_t             ofs [num_ports];
    logic [$clog2(max_len+1)-1:0] rem [num_ports];  // data words left
    logic [port_w-1:0]     d, d2;
    logic [qid_w-1:0]      q_hi, q_lo, sel_q, eq;
    logic                  ph1, ph2, avail, rd, start_pkt, deq_last, pkt_end;
    logic                  stat_q, hit_q, hdr_q;
    page_ptr_t             pg_now;
    word_ofs_t             ofs_now;
    pkt_word_u             rword;

    assign d         = wb_adr[port_w-1:0];
    assign q_hi      = {d, 1'b1};
    assign q_lo      = {d, 1'b0};
    assign sel_q     = q_ne[q_hi] ? q_hi : q_lo;    // priority 1 first
    assign avail     = active[d] || q_ne[q_hi] || q_ne[q_lo];
    assign rd        = ph1 && !wb_adr[2] && !wb_we && avail;
    assign start_pkt = rd && !active[d];            // header word of a new packet
    assign deq_last  = start_pkt && head[sel_q] == tail[sel_q];
    assign pkt_end   = rd && active[d] && rem[d] == 1;
    assign pg_now    = active[d] ? cur_pg[d] : head[sel_q];
    assign ofs_now   = active[d] ? ofs[d] : '0;
    assign raddr     = {pg_now, ofs_now};
    assign link_addr = pg_now;
    assign free_push = rd && (ofs_now == word_ofs_t'(page_words - 1) || pkt_end);
    assign free_in   = pg_now;
    assign eq        = dq.desc.qid;
    assign rword.data = rdata;
    assign wb_ack    = ph2;
    assign wb_dat_o  = stat_q ? word_w'(q_ne) : (hit_q ? rdata : '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ph1    <= 1'b0;
            ph2    <= 1'b0;
            active <= '0;
            q_ne   <= '0;
        end else begin
            ph1 <= wb_cyc && wb_stb && !ph1 && !ph2;   // address phase
            ph2 <= ph1;                                // data phase, ack
            if (start_pkt) begin
                active[d] <= 1'b1;
                if (deq_last) begin
                    q_ne[sel_q] <= 1'b0;
                end
            end
            if (pkt_end) begin
                active[d] <= 1'b0;
            end
            if (dq.valid) begin
                q_ne[eq] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ph1) begin
            stat_q <= wb_adr[2];
            hit_q  <= rd;
            hdr_q  <= start_pkt;
            d2     <= d;
        end
        if (rd) begin
            ofs[d]    <= ofs_now + 1'b1;
            cur_pg[d] <= (ofs_now == word_ofs_t'(page_words - 1)) ? link_data : pg_now;
            rem[d]    <= rem[d] - 1'b1;
        end
        if (ph2 && hdr_q) begin
            rem[d2] <= rword.hdr.length;   // length from the stored header
        end
        if (start_pkt && !deq_last) begin
            head[sel_q] <= pnext[head[sel_q]];
        end
        // enqueue last, so it wins over a dequeue that empties the same queue
        if (dq.valid) begin
            if (!q_ne[eq] || (deq_last && sel_q == eq)) begin
                head[eq] <= dq.desc.first;
            end else begin
                pnext[tail[eq]] <= dq.desc.first;
            end
            tail[eq] <= dq.desc.first;
        end
    end
endmodule

//--- switch_top.sv
`timescale 1ns/1ps

module switch_top (
    input  logic                                                   clk,
    input  logic                                                   arst_n,
    input  logic [switch_pkg::num_ports-1:0]                       wr_sop,
    input  logic [switch_pkg::num_ports-1:0]                       wr_eop,
    input  logic [switch_pkg::num_ports-1:0]                       wr_vld,
    input  logic [switch_pkg::num_ports-1:0][switch_pkg::word_w-1:0] wr_data,
    output logic [switch_pkg::num_ports-1:0]                       full,
    output logic [switch_pkg::num_ports-1:0]                       almost_full,
    input  logic                                                   wb_cyc,
    input  logic                                                   wb_stb,
    input  logic                                                   wb_we,
    input  logic [2:0]                                             wb_adr,
    output logic [switch_pkg::word_w-1:0]                          wb_dat_o,
    output logic                                                   wb_ack
);
    import switch_pkg::*;
    import buffer_pkg::*;

    logic              we, link_we;
    logic              free_pop, free_empty, free_push;
    logic [addr_w-1:0] waddr, raddr;
    logic [word_w-1:0] wdata, rdata;
    page_ptr_t         link_from, link_to, link_addr, link_data;
    page_ptr_t         free_ptr, free_in;

    page_if pg [num_ports] ();
    desc_if dq ();

    for (genvar i = 0; i < num_ports; i++) begin : g_in
        ingress_port u_port (
            .clk         (clk),
            .arst_n      (arst_n),
            .sop         (wr_sop[i]),
            .eop         (wr_eop[i]),
            .vld         (wr_vld[i]),
            .data        (wr_data[i]),
            .full        (full[i]),
            .almost_full (almost_full[i]),
            .pg          (pg[i])
        );
    end

    page_writer u_writer (
        .clk        (clk),
        .arst_n     (arst_n),
        .pg         (pg),
        .dq         (dq),
        .we         (we),
        .waddr      (waddr),
        .wdata      (wdata),
        .link_we    (link_we),
        .link_from  (link_from),
        .link_to    (link_to),
        .free_pop   (free_pop),
        .free_ptr   (free_ptr),
        .free_empty (free_empty)
    );

    buffer_memory u_mem (
        .clk        (clk),
        .arst_n     (arst_n),
        .we         (we),
        .waddr      (waddr),
        .wdata      (wdata),
        .raddr      (raddr),
        .rdata      (rdata),
        .link_we    (link_we),
        .link_from  (link_from),
        .link_to    (link_to),
        .link_addr  (link_addr),
        .link_data  (link_data),
        .free_pop   (free_pop),
        .free_ptr   (free_ptr),
        .free_empty (free_empty),
        .free_push  (free_push),
        .free_in    (free_in)
    );

    egress_reader u_reader (
        .clk       (clk),
        .arst_n    (arst_n),
        .dq        (dq),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_o  (wb_dat_o),
        .wb_ack    (wb_ack),
        .raddr     (raddr),
        .rdata     (rdata),
        .link_addr (link_addr),
        .link_data (link_data),
        .free_push (free_push),
        .free_in   (free_in)
    );
endmodule

//--- tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic arst_n
);
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;    // 8 ns period
    end

    initial begin
        arst_n = 1'b0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;           // release just after an edge
    end
endmodule

//--- tb_switch.sv
`timescale 1ns/1ps

module tb_switch;
    import switch_pkg::*;
    import buffer_pkg::*;

    localparam int total_pkts  = 81;    // packets sent over all tests
    localparam int cycle_limit = (total_pkts * (max_len + 1) + 100) * 8;

    logic                             clk;
    logic                             arst_n;
    logic [num_ports-1:0]             wr_sop;
    logic [num_ports-1:0]             wr_eop;
    logic [num_ports-1:0]             wr_vld;
    logic [num_ports-1:0][word_w-1:0] wr_data;
    logic [num_ports-1:0]             full;
    logic [num_ports-1:0]             almost_full;
    logic                             wb_cyc;
    logic                             wb_stb;
    logic                             wb_we;
    logic [2:0]                       wb_adr;
    logic [word_w-1:0]                wb_dat_o;
    logic                             wb_ack;

    logic [15:0] lfsr = 16'd21909;
    logic [5:0]  seq [num_ports] = '{default: '0};
    logic [15:0] exp_q [num_queues * num_ports][$];   // per queue and source port
    int          pending = 0;                         // words still expected
    int          errors = 0;
    int          failed = 0;
    int          cycles = 0;
    bit          sending = 1'b0;
    int          held [num_ports] = '{default: 0};    // words in each staging page
    logic [num_ports-1:0] full_q = '0;

    tb_clock u_clock (.clk(clk), .arst_n(arst_n));

    switch_top DUT (.*);

    function automatic logic [15:0] lfsr_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[14:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);  // galois step
        end
        return v;
    endfunction

    function automatic logic [4:0] pick_len();
        logic [4:0] l;
        l = 5'(lfsr_bits(5));
        return (l == 5'd0) ? 5'd1 : l;
    endfunction

    task automatic send_packet(input int p, input logic [1:0] dest, input logic prio,
                               input logic [4:0] len);
        logic [15:0] w [max_len + 1];
        int          n;
        int          last;
        last = int'(len);
        w[0] = {dest, prio, 2'(p), seq[p], len};   // spare holds port and sequence
        seq[p] = seq[p] + 6'd1;
        for (int i = 1; i <= last; i++) begin
            w[i] = lfsr_bits(16);
        end
        n = 0;
        for (int i = 0; i <= last; i++) begin
            repeat (lfsr_bits(2)) begin      // idle gap
                @(posedge clk);
                wr_vld[p] <= 1'b0;
            end
            @(posedge clk);
            wr_vld[p]  <= 1'b1;
            wr_sop[p]  <= (i == 0);
            wr_eop[p]  <= (i == last);
            wr_data[p] <= w[i];
            n++;
            if (i == last) begin
                for (int j = 0; j <= last; j++) begin
                    exp_q[{dest, prio} * num_ports + p].push_back(w[j]);
                end
                pending += last + 1;
            end
            if (n == 8 || i == last) begin   // page staged, wait for the writer
                @(posedge clk);
                wr_vld[p] <= 1'b0;
                @(posedge clk);
                assert (full[p]) else begin
                    $display("full on port %0d did not rise after a staged page at %0t",
                             p, $time);
                    errors++;
                end
                while (full[p]) @(posedge clk);
                n = 0;
            end
        end
    endtask

    task automatic send_burst(input int p, input int n, input int dest_fix, input int len_fix);
        logic [1:0] dst;
        logic [4:0] len;
        for (int i = 0; i < n; i++) begin
            dst = (dest_fix < 0) ? 2'(lfsr_bits(2)) : 2'(dest_fix);
            len = (len_fix > 0) ? 5'(len_fix) : pick_len();
            send_packet(p, dst, 1'(lfsr_bits(1)), len);
        end
    endtask

    task automatic wb_read(input logic [2:0] adr, output logic [15:0] dat);
        int n;
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_adr <= adr;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!wb_ack && n < 20);
        assert (wb_ack) else begin
            $display("no wb_ack within 20 cycles of the strobe, at %0t", $time);
            errors++;
        end
        if (wb_ack) begin
            assert (n - 1 == 2) else begin   // counted from the first sampling edge
                $display("ERR %0t wb_ack latency got %0d exp 2", $time, n - 1);
                errors++;
            end
        end
        dat = wb_dat_o;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    task automatic check_word(input int k, input logic [15:0] got);
        logic [15:0] exp;
        assert (exp_q[k].size() > 0) else begin
            $display("word %h came from queue %0d port %0d with nothing expected, at %0t",
                     got, k / num_ports, k % num_ports, $time);
            errors++;
        end
        if (exp_q[k].size() > 0) begin
            exp = exp_q[k].pop_front();
            pending--;
            assert (got == exp) else begin
                $display("ERR %0t wb_dat_o got %h exp %h", $time, got, exp);
                errors++;
            end
        end
    endtask

    task automatic read_packet(input logic [1:0] d, input bit prio_chk);
        pkt_word_u   h;
        logic [15:0] v;
        int          k;
        wb_read({1'b0, d}, v);
        h.data = v;
        k = {h.hdr.dest, h.hdr.prior} * num_ports + h.hdr.spare[7:6];
        assert (h.hdr.dest == d) else begin
            $display("ERR %0t header dest got %0d exp %0d", $time, h.hdr.dest, d);
            errors++;
        end
        if (prio_chk && !h.hdr.prior) begin
            for (int p = 0; p < num_ports; p++) begin
                assert (exp_q[{d, 1'b1} * num_ports + p].size() == 0) else begin
                    $display("priority 0 packet of dest %0d came before priority 1, at %0t",
                             d, $time);
                    errors++;
                end
            end
        end
        check_word(k, v);
        for (int i = 0; i < int'(h.hdr.length); i++) begin
            wb_read({1'b0, d}, v);
            check_word(k, v);
        end
    endtask

    task automatic drain_queues(input bit prio_chk);
        logic [15:0] st;
        int          q;
        repeat (4) @(posedge clk);   // last descriptors land in the queues
        while (pending > 0 || sending) begin
            wb_read(3'd4, st);
            if (st[7:0] == 8'h00) begin
                repeat (4) @(posedge clk);
            end else begin
                q = 0;
                while (!st[q]) q++;   // lowest busy queue
                read_packet(2'(q / 2), prio_chk);
            end
        end
    endtask

    task automatic report_test(input int n, input string name, input int mark);
        if (errors == mark) begin
            $display("test %0d %s: ok", n, name);
        end else begin
            $display("test %0d %s: %0d errors", n, name, errors - mark);
            failed++;
        end
    endtask

    // staging count restarts once full falls after the writer's done
    always @(posedge clk) begin
        if (arst_n) begin
            for (int p = 0; p < num_ports; p++) begin
                if (full_q[p] && !full[p]) begin
                    held[p] = 0;
                end
                assert (almost_full[p] == (held[p] == page_words - 1)) else begin
                    $display("ERR %0t almost_full[%0d] got %b exp %b",
                             $time, p, almost_full[p], held[p] == page_words - 1);
                    errors++;
                end
                if (wr_vld[p]) begin
                    held[p] = held[p] + 1;
                end
            end
        end
        full_q <= full;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, traffic did not complete", cycles);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        int          mark;
        int          stall;
        logic [15:0] st;
        logic [1:0]  d0;
        logic        p0;
        wr_sop  = '0;
        wr_eop  = '0;
        wr_vld  = '0;
        wr_data = '0;
        wb_cyc  = 1'b0;
        wb_stb  = 1'b0;
        wb_we   = 1'b0;
        wb_adr  = '0;
        wait (arst_n === 1'b1);
        repeat (2) @(posedge clk);

        mark = errors;
        d0 = 2'(lfsr_bits(2));
        p0 = 1'(lfsr_bits(1));
        send_packet(0, d0, p0, pick_len());
        do begin
            wb_read(3'd4, st);
        end while (!st[{d0, p0}]);
        read_packet(d0, 1'b1);
        report_test(1, "single packet round trip", mark);

        mark = errors;
        for (int i = 0; i < 8; i++) begin
            send_burst(int'(lfsr_bits(2)), 1, -1, 0);
        end
        drain_queues(1'b1);
        report_test(2, "multi-page packets", mark);

        mark = errors;
        for (int i = 0; i < 8; i++) begin
            send_packet(int'(lfsr_bits(2)), 2'd2, 1'(i % 2), pick_len());
        end
        drain_queues(1'b1);
        report_test(3, "priority order", mark);

        mark = errors;
        sending = 1'b1;
        fork
            begin
                fork
                    send_burst(0, 6, -1, 0);
                    send_burst(1, 6, -1, 0);
                    send_burst(2, 6, -1, 0);
                    send_burst(3, 6, -1, 0);
                join
                sending = 1'b0;
            end
            drain_queues(1'b0);
        join
        report_test(4, "concurrent ports and back-pressure", mark);

        mark = errors;
        sending = 1'b1;
        fork
            begin
                fork
                    send_burst(0, 6, -1, max_len);
                    send_burst(1, 6, -1, max_len);
                    send_burst(2, 6, -1, max_len);
                    send_burst(3, 6, -1, max_len);
                join
                sending = 1'b0;
            end
            begin
                stall = 0;
                while (stall < 40 && sending) begin   // every port stuck behind an empty free list
                    @(posedge clk);
                    stall = (&full) ? stall + 1 : 0;
                end
                assert (stall >= 40) else begin
                    $display("buffer never filled, full did not hold on every port");
                    errors++;
                end
                drain_queues(1'b0);
            end
        join
        fork
            send_burst(0, 4, -1, max_len);   // 64 pages in total
            send_burst(1, 4, -1, max_len);
            send_burst(2, 4, -1, max_len);
            send_burst(3, 4, -1, max_len);
        join
        drain_queues(1'b1);
        report_test(5, "buffer exhaustion and recycling", mark);

        mark = errors;
        wb_read(3'd4, st);
        assert (st == 16'h0000) else begin
            $display("ERR %0t wb_dat_o status got %h exp 0000", $time, st);
            errors++;
        end
        for (int d = 0; d < num_ports; d++) begin
            wb_read(3'(d), st);
            assert (st == 16'h0000) else begin
                $display("ERR %0t wb_dat_o empty dest %0d got %h exp 0000", $time, d, st);
                errors++;
            end
        end
        report_test(6, "status and empty reads", mark);

        $display("6 tests, %0d failed, %0d errors", failed, errors);
        if (errors == 0 && failed == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end
endmodule

//--- sim.f
switch_pkg.sv
buffer_pkg.sv
page_if.sv
desc_if.sv
ingress_port.sv
page_writer.sv
buffer_memory.sv
egress_reader.sv
switch_top.sv
tb_clock.sv
tb_switch.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_switch
RTL_TOP   = switch_top
FILELIST  = sim.f
OBJ_DIR   = obj_dir
SRCS      = $(shell cat $(FILELIST))

.PHONY: all lint clean

all: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
